//--- common/fetch_params.svh
// fetch front end constants: reset vector, apb register map and register reset values
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// program counter value after reset
`define FETCH_RESET_PC     32'h6000_0000

// apb byte offsets of the register block
`define FETCH_REG_CTRL     8'h00
`define FETCH_REG_PERIOD   8'h04
`define FETCH_REG_VECTOR   8'h08
`define FETCH_REG_DBG_PC   8'h0C

// timer period and handler vector after reset
`define FETCH_PERIOD_RESET 32'd64
`define FETCH_VECTOR_RESET 32'h6000_1000

`endif

//--- common/fetch_pkg.sv
// fetch front end types: address and data vectors, interrupt states, fetch packet and apb bus
package fetch_pkg;

  // byte address of an instruction
  typedef logic [31:0] addr_t;

  // data word on the apb bus
  typedef logic [31:0] word_t;

  // byte enables of an instruction memory read
  typedef logic [3:0] rmask_t;

  // interrupt sequencer states, only one handler level exists
  typedef enum logic [1:0] {
    INT_IDLE,
    INT_PENDING,
    INT_HANDLER
  } int_state_t;

  // fetch stage register handed to decode
  typedef struct packed {
    addr_t pc;
    addr_t pc_next;
    logic  int_flag;
    logic  valid;
  } fetch_pkt_t;

  // apb request from the master
  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    word_t      pwdata;
  } apb_req_t;

  // apb response from the slave
  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

endpackage

//--- fetch/fetch_pc_unit.sv
// fetch stage program counter with branch redirect, compressed correction and interrupt entry
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_pc_unit import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_stall,
  input  logic       i_branch_flush,
  input  addr_t      i_branch_target,
  input  logic       i_compressed,
  input  logic       i_end_int,
  input  logic       i_int_start,
  input  logic       i_int_active,
  input  addr_t      i_vector,
  input  logic       i_dbg_pc_we,
  input  addr_t      i_dbg_pc,
  output addr_t      o_imem_addr,
  output rmask_t     o_imem_rmask,
  output addr_t      o_pc,
  output fetch_pkt_t o_fetch
);

  // current program counter
  addr_t pc;
  // return address for the handler, written on interrupt entry
  addr_t saved_pc;
  // address sent to instruction memory this cycle
  addr_t fetch_addr;
  // sequential successor of the fetch address
  addr_t fetch_addr_inc;

  // a flush wins over everything since younger instructions are speculative
  // mret comes next and returns to the saved pc
  // a compressed instruction means the last fetch overshot by two bytes
  always_comb begin
    if (i_branch_flush) begin
      fetch_addr = i_branch_target;
    end else if (i_end_int) begin
      fetch_addr = saved_pc;
    end else if (i_compressed) begin
      fetch_addr = pc - 32'd2;
    end else begin
      fetch_addr = pc;
    end
  end

  assign fetch_addr_inc = fetch_addr + 32'd4;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= `FETCH_RESET_PC;
      saved_pc <= '0;
    end else begin
      // the debug write lands even while the pipeline is stalled
      if (i_dbg_pc_we) begin
        pc <= i_dbg_pc;
      end else if (!i_stall) begin
        if (i_int_start) begin
          // jump to the handler and remember where sequential fetch would go
          pc       <= i_vector;
          saved_pc <= fetch_addr_inc;
        end else begin
          pc <= fetch_addr_inc;
        end
      end
    end
  end

  // no read is issued while stalled
  assign o_imem_addr  = fetch_addr;
  assign o_imem_rmask = i_stall ? 4'h0 : 4'hF;

  // live pc for debug reads over apb
  assign o_pc = pc;

  // the packet records the address issued one cycle earlier and holds under stall
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_fetch <= '0;
    end else if (!i_stall) begin
      o_fetch.pc      <= fetch_addr;
      o_fetch.pc_next <= fetch_addr_inc;
      // the word fetched on mret already belongs to the interrupted program
      o_fetch.int_flag <= i_int_active && !i_end_int;
      o_fetch.valid    <= 1'b1;
    end
  end

endmodule

//--- fetch/fetch_int_ctrl.sv
// interrupt sequencer that holds a timer tick until a stall-free cycle and tracks the handler
`timescale 1ns/1ps

module fetch_int_ctrl import fetch_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic i_tick,
  input  logic i_stall,
  input  logic i_end_int,
  output logic o_int_start,
  output logic o_int_active
);

  int_state_t state;
  int_state_t state_next;

  // entry needs a free pipeline and must not collide with an mret
  assign o_int_start = (state == INT_PENDING) && !i_stall && !i_end_int;

  always_comb begin
    state_next = state;
    case (state)
      INT_IDLE: begin
        if (i_tick) begin
          state_next = INT_PENDING;
        end
      end
      INT_PENDING: begin
        // further ticks are absorbed here since one request is already waiting
        if (o_int_start) begin
          state_next = INT_HANDLER;
        end
      end
      INT_HANDLER: begin
        // ticks during the handler are dropped, nesting is not supported
        if (i_end_int) begin
          state_next = INT_IDLE;
        end
      end
      default: begin
        state_next = INT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= INT_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign o_int_active = (state == INT_HANDLER);

endmodule

//--- design/int_timer.sv
// periodic timer that raises a one-cycle tick each time its counter wraps
`timescale 1ns/1ps

module int_timer import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_enable,
  input  word_t i_period,
  output logic  o_tick
);

  word_t count;
  // last count value before the wrap
  word_t limit;
  logic  wrap;

  // a zero period behaves like a period of one
  assign limit = (i_period == '0) ? '0 : i_period - 32'd1;

  // compare with >= so a period lowered mid-count still wraps
  assign wrap = (count >= limit);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count  <= '0;
      o_tick <= 1'b0;
    end else if (!i_enable) begin
      // disabling restarts the period from zero
      count  <= '0;
      o_tick <= 1'b0;
    end else begin
      o_tick <= wrap;
      if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 32'd1;
      end
    end
  end

endmodule

//--- design/fetch_apb_regs.sv
// apb slave holding timer control, timer period, handler vector and the debug pc port
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_apb_regs import fetch_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t i_apb,
  output apb_rsp_t o_apb,
  input  addr_t    i_pc,
  output logic     o_timer_en,
  output word_t    o_period,
  output addr_t    o_vector,
  output logic     o_dbg_pc_we,
  output addr_t    o_dbg_pc
);

  logic access;
  logic hit;
  logic wr;

  // zero wait states, so every access phase completes at once
  assign access = i_apb.psel && i_apb.penable;
  assign wr     = access && i_apb.pwrite;

  always_comb begin
    hit            = 1'b1;
    o_apb.prdata   = '0;
    case (i_apb.paddr)
      `FETCH_REG_CTRL:   o_apb.prdata = {31'd0, o_timer_en};
      `FETCH_REG_PERIOD: o_apb.prdata = o_period;
      `FETCH_REG_VECTOR: o_apb.prdata = o_vector;
      // debug reads see the pc the fetch stage holds right now
      `FETCH_REG_DBG_PC: o_apb.prdata = i_pc;
      default:           hit = 1'b0;
    endcase
    // the slave is always ready and flags offsets outside the map
    o_apb.pready  = 1'b1;
    o_apb.pslverr = access && !hit;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_timer_en <= 1'b0;
      o_period   <= `FETCH_PERIOD_RESET;
      o_vector   <= `FETCH_VECTOR_RESET;
    end else if (wr) begin
      case (i_apb.paddr)
        `FETCH_REG_CTRL:   o_timer_en <= i_apb.pwdata[0];
        `FETCH_REG_PERIOD: o_period   <= i_apb.pwdata;
        `FETCH_REG_VECTOR: o_vector   <= i_apb.pwdata;
        default:           ;
      endcase
    end
  end

  // the pc write is a strobe for the access cycle, the fetch stage takes it at that edge
  assign o_dbg_pc_we = wr && (i_apb.paddr == `FETCH_REG_DBG_PC);
  assign o_dbg_pc    = i_apb.pwdata;

endmodule

//--- design/fetch_top.sv
// fetch front end top: register block, timer, interrupt sequencer and fetch stage
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  apb_req_t   i_apb,
  input  logic       i_stall,
  input  logic       i_branch_flush,
  input  addr_t      i_branch_target,
  input  logic       i_compressed,
  input  logic       i_end_int,
  output apb_rsp_t   o_apb,
  output addr_t      o_imem_addr,
  output rmask_t     o_imem_rmask,
  output fetch_pkt_t o_fetch,
  output logic       o_int_active
);

  // register block outputs
  logic  timer_en;
  word_t period;
  addr_t vector;
  logic  dbg_pc_we;
  addr_t dbg_pc;
  // pc read back for debug
  addr_t pc;
  // interrupt path
  logic  tick;
  logic  int_start;

  fetch_apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .i_apb      (i_apb),
    .o_apb      (o_apb),
    .i_pc       (pc),
    .o_timer_en (timer_en),
    .o_period   (period),
    .o_vector   (vector),
    .o_dbg_pc_we(dbg_pc_we),
    .o_dbg_pc   (dbg_pc)
  );

  int_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .i_enable(timer_en),
    .i_period(period),
    .o_tick  (tick)
  );

  fetch_int_ctrl u_int_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_tick      (tick),
    .i_stall     (i_stall),
    .i_end_int   (i_end_int),
    .o_int_start (int_start),
    .o_int_active(o_int_active)
  );

  fetch_pc_unit u_pc_unit (
    .clk            (clk),
    .rst            (rst),
    .i_stall        (i_stall),
    .i_branch_flush (i_branch_flush),
    .i_branch_target(i_branch_target),
    .i_compressed   (i_compressed),
    .i_end_int      (i_end_int),
    .i_int_start    (int_start),
    .i_int_active   (o_int_active),
    .i_vector       (vector),
    .i_dbg_pc_we    (dbg_pc_we),
    .i_dbg_pc       (dbg_pc),
    .o_imem_addr    (o_imem_addr),
    .o_imem_rmask   (o_imem_rmask),
    .o_pc           (pc),
    .o_fetch        (o_fetch)
  );

endmodule

//--- test/tb_fetch_top.sv
// fetch front end testbench with a reference pc model under random stall, branch and interrupts
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_top import fetch_pkg::*; ();

  logic       clk;
  logic       rst;
  apb_req_t   apb_req;
  logic       stall;
  logic       flush;
  addr_t      target;
  logic       comp;
  logic       endi;
  apb_rsp_t   apb_rsp;
  addr_t      imem_addr;
  rmask_t     imem_rmask;
  fetch_pkt_t fetch;
  logic       int_active;

  // reference model state, advanced once per rising edge
  addr_t       m_pc;
  addr_t       m_saved;
  addr_t       m_addr;
  addr_t       m_vector;
  word_t       m_period;
  word_t       m_count;
  logic        m_en;
  logic        m_tick;
  int_state_t  m_state;
  fetch_pkt_t  m_pkt;
  logic [31:0] rnd = 32'd92;
  int unsigned cycles = 0;
  int          entries = 0;
  int          handler_len = 0;

  fetch_top UUT (
    .clk            (clk),
    .rst            (rst),
    .i_apb          (apb_req),
    .i_stall        (stall),
    .i_branch_flush (flush),
    .i_branch_target(target),
    .i_compressed   (comp),
    .i_end_int      (endi),
    .o_apb          (apb_rsp),
    .o_imem_addr    (imem_addr),
    .o_imem_rmask   (imem_rmask),
    .o_fetch        (fetch),
    .o_int_active   (int_active)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // the whole sequence takes about 1200 cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 4000) begin
      $display("timeout: the run went past 4000 clock cycles");
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string name, input logic [65:0] got,
                                 input logic [65:0] exp);
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic known_offset(input logic [7:0] off);
    return (off == `FETCH_REG_CTRL) || (off == `FETCH_REG_PERIOD) ||
           (off == `FETCH_REG_VECTOR) || (off == `FETCH_REG_DBG_PC);
  endfunction

  // read data the register map should return for a given offset
  function automatic word_t model_rdata(input logic [7:0] off);
    case (off)
      `FETCH_REG_CTRL:   return {31'd0, m_en};
      `FETCH_REG_PERIOD: return m_period;
      `FETCH_REG_VECTOR: return m_vector;
      `FETCH_REG_DBG_PC: return m_pc;
      default:           return '0;
    endcase
  endfunction

  // one clock: check the combinational outputs, step the model, then check the registers
  task automatic run_cycle();
    logic       acc;
    logic       wr;
    logic       start;
    rmask_t     exp_mask;
    word_t      limit;
    int_state_t st_next;
    #1;
    if (flush) begin
      m_addr = target;
    end else if (endi) begin
      m_addr = m_saved;
    end else if (comp) begin
      m_addr = m_pc - 32'd2;
    end else begin
      m_addr = m_pc;
    end
    exp_mask = stall ? 4'h0 : 4'hF;
    acc = apb_req.psel && apb_req.penable;
    assert (imem_addr == m_addr) else report_mismatch("o_imem_addr", 66'(imem_addr), 66'(m_addr));
    assert (imem_rmask == exp_mask)
      else report_mismatch("o_imem_rmask", 66'(imem_rmask), 66'(exp_mask));
    assert (apb_rsp.pready) else report_mismatch("o_apb.pready", 66'(apb_rsp.pready), 66'd1);
    if (acc) begin
      assert (apb_rsp.pslverr == !known_offset(apb_req.paddr))
        else report_mismatch("o_apb.pslverr", 66'(apb_rsp.pslverr),
                             66'(!known_offset(apb_req.paddr)));
      if (!apb_req.pwrite && known_offset(apb_req.paddr)) begin
        assert (apb_rsp.prdata == model_rdata(apb_req.paddr))
          else report_mismatch("o_apb.prdata", 66'(apb_rsp.prdata),
                               66'(model_rdata(apb_req.paddr)));
      end
    end else begin
      // no error response outside an access phase
      assert (!apb_rsp.pslverr)
        else report_mismatch("o_apb.pslverr", 66'(apb_rsp.pslverr), 66'd0);
    end
    @(posedge clk);
    wr = acc && apb_req.pwrite;
    start = (m_state == INT_PENDING) && !stall && !endi;
    if (start) begin
      entries++;
    end
    // state moves on the tick registered before this edge
    st_next = m_state;
    case (m_state)
      INT_IDLE:    st_next = m_tick ? INT_PENDING : INT_IDLE;
      INT_PENDING: st_next = start ? INT_HANDLER : INT_PENDING;
      INT_HANDLER: st_next = endi ? INT_IDLE : INT_HANDLER;
      default:     st_next = INT_IDLE;
    endcase
    if (wr && apb_req.paddr == `FETCH_REG_DBG_PC) begin
      m_pc = apb_req.pwdata;
    end else if (!stall && start) begin
      m_pc = m_vector;
      m_saved = m_addr + 32'd4;
    end else if (!stall) begin
      m_pc = m_addr + 32'd4;
    end
    if (!stall) begin
      m_pkt.pc = m_addr;
      m_pkt.pc_next = m_addr + 32'd4;
      m_pkt.int_flag = (m_state == INT_HANDLER) && !endi;
      m_pkt.valid = 1'b1;
    end
    m_state = st_next;
    // tick comes in the cycle the count wraps from period minus one
    limit = (m_period == '0) ? '0 : m_period - 32'd1;
    if (!m_en) begin
      m_count = '0;
      m_tick = 1'b0;
    end else begin
      m_tick = (m_count == limit);
      m_count = m_tick ? '0 : m_count + 32'd1;
    end
    if (wr && apb_req.paddr == `FETCH_REG_CTRL) m_en = apb_req.pwdata[0];
    if (wr && apb_req.paddr == `FETCH_REG_PERIOD) m_period = apb_req.pwdata;
    if (wr && apb_req.paddr == `FETCH_REG_VECTOR) m_vector = apb_req.pwdata;
    @(negedge clk);
    assert (fetch == m_pkt) else report_mismatch("o_fetch", 66'(fetch), 66'(m_pkt));
    assert (int_active == (m_state == INT_HANDLER))
      else report_mismatch("o_int_active", 66'(int_active), 66'(m_state == INT_HANDLER));
  endtask

  task automatic apb_access(input logic write, input logic [7:0] off, input word_t data);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = off;
    apb_req.pwdata = data;
    run_cycle();
    apb_req.penable = 1'b1;
    run_cycle();
    apb_req = '0;
  endtask

  initial begin
    rst = 1'b1;
    apb_req = '0;
    stall = 1'b0;
    flush = 1'b0;
    target = '0;
    comp = 1'b0;
    endi = 1'b0;
    m_pc = `FETCH_RESET_PC;
    m_saved = '0;
    m_addr = '0;
    m_vector = `FETCH_VECTOR_RESET;
    m_period = `FETCH_PERIOD_RESET;
    m_count = '0;
    m_en = 1'b0;
    m_tick = 1'b0;
    m_state = INT_IDLE;
    m_pkt = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // plain sequential fetch from the reset vector
    repeat (40) run_cycle();
    repeat (200) begin
      rnd = next_rand(rnd);
      stall = (rnd[31:30] == 2'b00);
      run_cycle();
    end
    // branch targets stay halfword aligned inside the code region
    repeat (300) begin
      rnd = next_rand(rnd);
      stall = (rnd[31:30] == 2'b00);
      flush = (rnd[29:27] == 3'b000);
      comp = (rnd[26:25] == 2'b00);
      target = `FETCH_RESET_PC + {18'd0, rnd[20:8], 1'b0};
      run_cycle();
    end
    stall = 1'b0;
    flush = 1'b0;
    comp = 1'b0;
    apb_access(1'b1, `FETCH_REG_PERIOD, 32'd40);
    apb_access(1'b1, `FETCH_REG_VECTOR, 32'h6000_2000);
    apb_access(1'b0, `FETCH_REG_PERIOD, '0);
    apb_access(1'b0, `FETCH_REG_VECTOR, '0);
    apb_access(1'b0, 8'h20, '0);
    apb_access(1'b1, 8'h20, 32'hDEAD_BEEF);
    apb_access(1'b1, `FETCH_REG_DBG_PC, 32'h6000_0400);
    apb_access(1'b0, `FETCH_REG_DBG_PC, '0);
    apb_access(1'b1, `FETCH_REG_CTRL, 32'd1);
    // handlers run longer than the period so a tick always lands inside one
    repeat (600) begin
      rnd = next_rand(rnd);
      stall = (rnd[31:30] == 2'b00);
      endi = 1'b0;
      if (m_state == INT_HANDLER) begin
        handler_len++;
        if (handler_len > 50 && !stall) endi = 1'b1;
      end else begin
        handler_len = 0;
      end
      run_cycle();
    end
    if (entries >= 2) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("the interrupt handler was entered fewer than two times");
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

//--- all.f
+incdir+common
common/fetch_pkg.sv
fetch/fetch_pc_unit.sv
fetch/fetch_int_ctrl.sv
design/int_timer.sv
design/fetch_apb_regs.sv
design/fetch_top.sv
test/tb_fetch_top.sv

//--- Makefile
TOP := tb_fetch_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir
